// File: rtl/rv_decode_macros.svh
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// Instruction queue entries, also the fetch credits held after reset
`define QUEUE_DEPTH 4

// Decoded packets the backend can absorb
`define BACKEND_CREDITS 2

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

// File: rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // Major opcodes
  localparam logic [6:0] opcode_lui = 7'b0110111;
  localparam logic [6:0] opcode_auipc = 7'b0010111;
  localparam logic [6:0] opcode_jal = 7'b1101111;
  localparam logic [6:0] opcode_jalr = 7'b1100111;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_load = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;
  localparam logic [6:0] opcode_immediate = 7'b0010011;
  localparam logic [6:0] opcode_register = 7'b0110011;
  localparam logic [6:0] opcode_fence = 7'b0001111;
  localparam logic [6:0] opcode_system = 7'b1110011;

  // Integer ALU funct3
  localparam logic [2:0] funct_add = 3'b000;
  localparam logic [2:0] funct_sll = 3'b001;
  localparam logic [2:0] funct_slt = 3'b010;
  localparam logic [2:0] funct_sltu = 3'b011;
  localparam logic [2:0] funct_xor = 3'b100;
  localparam logic [2:0] funct_srl = 3'b101;
  localparam logic [2:0] funct_or = 3'b110;
  localparam logic [2:0] funct_and = 3'b111;

  // M extension funct3
  localparam logic [2:0] funct_mul = 3'b000;
  localparam logic [2:0] funct_mulh = 3'b001;
  localparam logic [2:0] funct_mulhsu = 3'b010;
  localparam logic [2:0] funct_mulhu = 3'b011;
  localparam logic [2:0] funct_div = 3'b100;
  localparam logic [2:0] funct_divu = 3'b101;
  localparam logic [2:0] funct_rem = 3'b110;
  localparam logic [2:0] funct_remu = 3'b111;

  // SYSTEM funct3, 3'b100 is reserved
  localparam logic [2:0] funct_priv = 3'b000;
  localparam logic [2:0] funct_csrrw = 3'b001;
  localparam logic [2:0] funct_csrrs = 3'b010;
  localparam logic [2:0] funct_csrrc = 3'b011;
  localparam logic [2:0] funct_csrrwi = 3'b101;
  localparam logic [2:0] funct_csrrsi = 3'b110;
  localparam logic [2:0] funct_csrrci = 3'b111;

  // Privileged codes in the upper twelve bits
  localparam logic [11:0] csr_ecall = 12'h000;
  localparam logic [11:0] csr_ebreak = 12'h001;
  localparam logic [11:0] csr_wfi = 12'h105;
  localparam logic [11:0] csr_mret = 12'h302;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_view_type;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } i_view_type;

  typedef union packed {
    r_view_type r_view;
    i_view_type i_view;
  } instr_word_union;

endpackage

`default_nettype wire

// File: rtl/decode_pkg.sv
`default_nettype none

package decode_pkg;

  typedef struct packed {
    logic alu_add;
    logic alu_sub;
    logic alu_sll;
    logic alu_srl;
    logic alu_sra;
    logic alu_slt;
    logic alu_sltu;
    logic alu_and;
    logic alu_or;
    logic alu_xor;
  } alu_op_type;

  typedef struct packed {
    logic muls;
    logic mulh;
    logic mulhsu;
    logic mulhu;
  } mul_op_type;

  typedef struct packed {
    logic divs;
    logic divu;
    logic rem;
    logic remu;
  } div_op_type;

  typedef struct packed {
    logic csrrw;
    logic csrrs;
    logic csrrc;
    logic csrrwi;
    logic csrrsi;
    logic csrrci;
  } csr_op_type;

  localparam alu_op_type init_alu_op = '0;
  localparam mul_op_type init_mul_op = '0;
  localparam div_op_type init_div_op = '0;
  localparam csr_op_type init_csr_op = '0;

  typedef struct packed {
    logic hit;
    logic branch;
    logic jal;
    logic jalr;
    logic load;
    logic store;
    logic auipc;
    logic fence;
    logic wren;
    logic rden1;
    logic rden2;
    logic [31:0] imm;
  } predecoder_out_type;

  typedef struct packed {
    logic [31:0] instr;
  } postdecoder_in_type;

  typedef struct packed {
    logic [31:0] imm;
    logic wren;
    logic rden1;
    logic rden2;
    logic cwren;
    logic crden;
    logic lui;
    logic nop;
    logic csrreg;
    logic division;
    logic mult;
    alu_op_type alu_op;
    csr_op_type csr_op;
    div_op_type div_op;
    mul_op_type mul_op;
    logic ecall;
    logic ebreak;
    logic mret;
    logic wfi;
    logic valid;
  } postdecoder_out_type;

  typedef struct packed {
    logic legal;
    logic [31:0] instr;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [11:0] caddr;
    logic wren;
    logic rden1;
    logic rden2;
    logic cwren;
    logic crden;
    logic branch;
    logic jal;
    logic jalr;
    logic load;
    logic store;
    logic auipc;
    logic fence;
    logic lui;
    logic nop;
    logic csrreg;
    logic division;
    logic mult;
    logic ecall;
    logic ebreak;
    logic mret;
    logic wfi;
    alu_op_type alu_op;
    mul_op_type mul_op;
    div_op_type div_op;
    csr_op_type csr_op;
    logic [31:0] imm;
  } decode_out_type;

endpackage

`default_nettype wire

// File: rtl/instr_queue.sv
`default_nettype none
`include "rv_decode_macros.svh"

module instr_queue (
  input logic clk,
  input logic rst_n,
  input logic fetch_valid,
  input logic [31:0] fetch_instr,
  input logic pop,
  output logic queue_valid,
  output logic [31:0] queue_instr,
  output logic fetch_credit
);

  localparam int ptr_w = $clog2(`QUEUE_DEPTH);
  localparam int cnt_w = $clog2(`QUEUE_DEPTH + 1);
  localparam logic [ptr_w-1:0] last_slot = ptr_w'(`QUEUE_DEPTH - 1);

  logic [31:0] mem [`QUEUE_DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  assign queue_valid = count != '0;
  assign queue_instr = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      mem[wr_ptr] <= fetch_instr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      fetch_credit <= 1'b0;
    end else begin
      if (fetch_valid) begin
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      end
      case ({fetch_valid, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;
      endcase
      // Each freed entry goes back to the sender as one credit
      fetch_credit <= pop;
    end
  end

  // Sender credit accounting must keep a full queue from being written
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_valid |-> count != cnt_w'(`QUEUE_DEPTH));

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> queue_valid);

endmodule

`default_nettype wire

// File: rtl/predecoder.sv
`default_nettype none

module predecoder
  import rv_isa_pkg::*, decode_pkg::*;
(
  input logic [31:0] instr,
  output predecoder_out_type predecoder_out
);

  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_u;
  logic nonzero_waddr;

  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'h000};
  assign nonzero_waddr = |instr[11:7];

  always_comb begin
    predecoder_out = '0;
    case (instr[6:0])
      opcode_branch: begin
        predecoder_out.hit = 1'b1;
        predecoder_out.branch = 1'b1;
        predecoder_out.rden1 = 1'b1;
        predecoder_out.rden2 = 1'b1;
        predecoder_out.imm = imm_b;
      end
      opcode_jal: begin
        predecoder_out.hit = 1'b1;
        predecoder_out.jal = 1'b1;
        predecoder_out.wren = nonzero_waddr;
        predecoder_out.imm = imm_j;
      end
      opcode_jalr: begin
        predecoder_out.hit = 1'b1;
        predecoder_out.jalr = 1'b1;
        predecoder_out.wren = nonzero_waddr;
        predecoder_out.rden1 = 1'b1;
        predecoder_out.imm = imm_i;
      end
      opcode_load: begin
        predecoder_out.hit = 1'b1;
        predecoder_out.load = 1'b1;
        predecoder_out.wren = nonzero_waddr;
        predecoder_out.rden1 = 1'b1;
        predecoder_out.imm = imm_i;
      end
      opcode_store: begin
        predecoder_out.hit = 1'b1;
        predecoder_out.store = 1'b1;
        predecoder_out.rden1 = 1'b1;
        predecoder_out.rden2 = 1'b1;
        predecoder_out.imm = imm_s;
      end
      opcode_auipc: begin
        predecoder_out.hit = 1'b1;
        predecoder_out.auipc = 1'b1;
        predecoder_out.wren = nonzero_waddr;
        predecoder_out.imm = imm_u;
      end
      // No register traffic, ordering only
      opcode_fence: begin
        predecoder_out.hit = 1'b1;
        predecoder_out.fence = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/postdecoder.sv
`default_nettype none
`include "rv_decode_macros.svh"

module postdecoder
  import rv_isa_pkg::*, decode_pkg::*;
(
  input postdecoder_in_type postdecoder_in,
  output postdecoder_out_type postdecoder_out
);

  logic [31:0] instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [11:0] caddr;
  logic [31:0] imm_c;
  logic [31:0] imm_i;
  logic [31:0] imm_u;
  logic nonzero_waddr;
  logic nonzero_src;

  assign instr = postdecoder_in.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign caddr = instr[31:20];

  assign imm_c = {27'b0, instr[19:15]};
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'h000};

  assign nonzero_waddr = |instr[11:7];
  // rs1 and zimm share bits 19:15
  assign nonzero_src = |instr[19:15];

  always_comb begin
    postdecoder_out = '0;
    postdecoder_out.alu_op = init_alu_op;
    postdecoder_out.mul_op = init_mul_op;
    postdecoder_out.div_op = init_div_op;
    postdecoder_out.csr_op = init_csr_op;
    postdecoder_out.valid = 1'b1;

    case (opcode)
      opcode_lui: begin
        postdecoder_out.imm = imm_u;
        postdecoder_out.wren = nonzero_waddr;
        postdecoder_out.lui = 1'b1;
      end
      opcode_immediate: begin
        postdecoder_out.imm = imm_i;
        postdecoder_out.wren = nonzero_waddr;
        postdecoder_out.rden1 = 1'b1;
        case (funct3)
          funct_add: postdecoder_out.alu_op.alu_add = 1'b1;
          funct_sll: begin
            postdecoder_out.alu_op.alu_sll = 1'b1;
            postdecoder_out.valid = funct7 == 7'b0000000;
          end
          funct_srl: begin
            postdecoder_out.alu_op.alu_srl = ~instr[30];
            postdecoder_out.alu_op.alu_sra = instr[30];
            postdecoder_out.valid = ~|{funct7[6], funct7[4:0]};
          end
          funct_slt: postdecoder_out.alu_op.alu_slt = 1'b1;
          funct_sltu: postdecoder_out.alu_op.alu_sltu = 1'b1;
          funct_and: postdecoder_out.alu_op.alu_and = 1'b1;
          funct_or: postdecoder_out.alu_op.alu_or = 1'b1;
          default: postdecoder_out.alu_op.alu_xor = 1'b1;
        endcase
      end
      opcode_register: begin
        postdecoder_out.wren = nonzero_waddr;
        postdecoder_out.rden1 = 1'b1;
        postdecoder_out.rden2 = 1'b1;
        if (funct7 == 7'b0000001) begin
          // Upper half of funct3 selects the divider
          postdecoder_out.mult = ~funct3[2];
          postdecoder_out.division = funct3[2];
          case (funct3)
            funct_mul: postdecoder_out.mul_op.muls = 1'b1;
            funct_mulh: postdecoder_out.mul_op.mulh = 1'b1;
            funct_mulhsu: postdecoder_out.mul_op.mulhsu = 1'b1;
            funct_mulhu: postdecoder_out.mul_op.mulhu = 1'b1;
            funct_div: postdecoder_out.div_op.divs = 1'b1;
            funct_divu: postdecoder_out.div_op.divu = 1'b1;
            funct_rem: postdecoder_out.div_op.rem = 1'b1;
            default: postdecoder_out.div_op.remu = 1'b1;
          endcase
        end else if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin
          case (funct3)
            funct_add: begin
              postdecoder_out.alu_op.alu_add = ~instr[30];
              postdecoder_out.alu_op.alu_sub = instr[30];
            end
            funct_srl: begin
              postdecoder_out.alu_op.alu_srl = ~instr[30];
              postdecoder_out.alu_op.alu_sra = instr[30];
            end
            funct_sll: postdecoder_out.alu_op.alu_sll = 1'b1;
            funct_slt: postdecoder_out.alu_op.alu_slt = 1'b1;
            funct_sltu: postdecoder_out.alu_op.alu_sltu = 1'b1;
            funct_and: postdecoder_out.alu_op.alu_and = 1'b1;
            funct_or: postdecoder_out.alu_op.alu_or = 1'b1;
            default: postdecoder_out.alu_op.alu_xor = 1'b1;
          endcase
          // Bit 30 only means something for sub and sra
          if (instr[30] && funct3 != funct_add && funct3 != funct_srl) begin
            postdecoder_out.valid = 1'b0;
          end
        end else begin
          postdecoder_out.valid = 1'b0;
        end
      end
      opcode_system: begin
        postdecoder_out.imm = imm_c;
        case (funct3)
          funct_priv: begin
            case (caddr)
              csr_ecall: postdecoder_out.ecall = 1'b1;
              csr_ebreak: postdecoder_out.ebreak = 1'b1;
              csr_mret: postdecoder_out.mret = 1'b1;
              csr_wfi: postdecoder_out.wfi = 1'b1;
              default: postdecoder_out.valid = 1'b0;
            endcase
          end
          funct_csrrw: begin
            postdecoder_out.csr_op.csrrw = 1'b1;
            postdecoder_out.rden1 = 1'b1;
            postdecoder_out.cwren = 1'b1;
            postdecoder_out.crden = nonzero_waddr;
          end
          funct_csrrs: begin
            postdecoder_out.csr_op.csrrs = 1'b1;
            postdecoder_out.rden1 = 1'b1;
            postdecoder_out.cwren = nonzero_src;
            postdecoder_out.crden = 1'b1;
          end
          funct_csrrc: begin
            postdecoder_out.csr_op.csrrc = 1'b1;
            postdecoder_out.rden1 = 1'b1;
            postdecoder_out.cwren = nonzero_src;
            postdecoder_out.crden = 1'b1;
          end
          funct_csrrwi: begin
            postdecoder_out.csr_op.csrrwi = 1'b1;
            postdecoder_out.cwren = 1'b1;
            postdecoder_out.crden = nonzero_waddr;
          end
          funct_csrrsi: begin
            postdecoder_out.csr_op.csrrsi = 1'b1;
            postdecoder_out.cwren = nonzero_src;
            postdecoder_out.crden = 1'b1;
          end
          funct_csrrci: begin
            postdecoder_out.csr_op.csrrci = 1'b1;
            postdecoder_out.cwren = nonzero_src;
            postdecoder_out.crden = 1'b1;
          end
          default: postdecoder_out.valid = 1'b0;
        endcase
        if (funct3 != funct_priv && postdecoder_out.valid) begin
          postdecoder_out.csrreg = 1'b1;
          postdecoder_out.wren = nonzero_waddr;
        end
      end
      default: postdecoder_out.valid = 1'b0;
    endcase

    if (instr == `NOP_INSTR) begin
      postdecoder_out.alu_op.alu_add = 1'b0;
      postdecoder_out.nop = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`default_nettype none
`include "rv_decode_macros.svh"

module decode_stage
  import rv_isa_pkg::*, decode_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic queue_valid,
  input logic [31:0] queue_instr,
  output logic pop,
  input logic dec_credit,
  output logic dec_valid,
  output decode_out_type dec_out
);

  localparam int cnt_w = $clog2(`BACKEND_CREDITS + 1);

  logic [cnt_w-1:0] credit_cnt;
  logic credit_ok;
  instr_word_union word;
  predecoder_out_type pre_out;
  postdecoder_in_type post_in;
  postdecoder_out_type post_out;
  decode_out_type merged;

  assign word = queue_instr;
  assign post_in.instr = queue_instr;

  predecoder predecoder_i (
    .instr(queue_instr),
    .predecoder_out(pre_out)
  );

  postdecoder postdecoder_i (
    .postdecoder_in(post_in),
    .postdecoder_out(post_out)
  );

  // A credit returned this cycle can be spent at once
  assign credit_ok = (credit_cnt != '0) || dec_credit;
  assign pop = queue_valid && credit_ok;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_cnt <= cnt_w'(`BACKEND_CREDITS);
      dec_valid <= 1'b0;
    end else begin
      // The credit is taken at the edge that raises dec_valid
      credit_cnt <= credit_cnt + cnt_w'(dec_credit) - cnt_w'(pop);
      dec_valid <= pop;
    end
  end

  always_comb begin
    merged = '0;
    merged.legal = pre_out.hit | post_out.valid;
    merged.instr = queue_instr;
    merged.rd = word.r_view.rd;
    merged.rs1 = word.r_view.rs1;
    merged.rs2 = word.r_view.rs2;
    merged.caddr = word.i_view.imm;
    if (pre_out.hit) begin
      merged.wren = pre_out.wren;
      merged.rden1 = pre_out.rden1;
      merged.rden2 = pre_out.rden2;
      merged.branch = pre_out.branch;
      merged.jal = pre_out.jal;
      merged.jalr = pre_out.jalr;
      merged.load = pre_out.load;
      merged.store = pre_out.store;
      merged.auipc = pre_out.auipc;
      merged.fence = pre_out.fence;
      merged.imm = pre_out.imm;
    end else begin
      merged.wren = post_out.wren;
      merged.rden1 = post_out.rden1;
      merged.rden2 = post_out.rden2;
      merged.cwren = post_out.cwren;
      merged.crden = post_out.crden;
      merged.lui = post_out.lui;
      merged.nop = post_out.nop;
      merged.csrreg = post_out.csrreg;
      merged.division = post_out.division;
      merged.mult = post_out.mult;
      merged.ecall = post_out.ecall;
      merged.ebreak = post_out.ebreak;
      merged.mret = post_out.mret;
      merged.wfi = post_out.wfi;
      merged.alu_op = post_out.alu_op;
      merged.mul_op = post_out.mul_op;
      merged.div_op = post_out.div_op;
      merged.csr_op = post_out.csr_op;
      merged.imm = post_out.imm;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      dec_out <= merged;
    end
  end

  // A packet in flight holds one backend credit
  a_valid_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid |-> credit_cnt < cnt_w'(`BACKEND_CREDITS));

  // Backend must never return more credits than it was given
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt <= cnt_w'(`BACKEND_CREDITS));

endmodule

`default_nettype wire

// File: rtl/decode_top.sv
`default_nettype none

module decode_top
  import decode_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic fetch_valid,
  input logic [31:0] fetch_instr,
  output logic fetch_credit,
  input logic dec_credit,
  output logic dec_valid,
  output decode_out_type dec_out
);

  logic queue_valid;
  logic [31:0] queue_instr;
  logic pop;

  instr_queue instr_queue_i (
    .clk(clk),
    .rst_n(rst_n),
    .fetch_valid(fetch_valid),
    .fetch_instr(fetch_instr),
    .pop(pop),
    .queue_valid(queue_valid),
    .queue_instr(queue_instr),
    .fetch_credit(fetch_credit)
  );

  decode_stage decode_stage_i (
    .clk(clk),
    .rst_n(rst_n),
    .queue_valid(queue_valid),
    .queue_instr(queue_instr),
    .pop(pop),
    .dec_credit(dec_credit),
    .dec_valid(dec_valid),
    .dec_out(dec_out)
  );

endmodule

`default_nettype wire

// File: testbench/decode_tb.sv
`default_nettype none
`include "rv_decode_macros.svh"

module decode_tb
  import rv_isa_pkg::*, decode_pkg::*;
();

  localparam int wait_limit = 200;

  logic clk;
  logic rst_n;
  logic fetch_valid;
  logic [31:0] fetch_instr;
  logic fetch_credit;
  logic dec_credit;
  logic dec_valid;
  decode_out_type dec_out;

  logic [15:0] lfsr_state;
  logic [31:0] sent_q[$];
  int owed_q[$];
  decode_out_type exp_pkt;
  logic hold_credits;
  int pending;
  int held;
  int send_credits;
  int cycle;
  int n_sent;
  int n_out;
  int credit_pulses;
  int errors;

  decode_top decode_top_i (
    .clk(clk),
    .rst_n(rst_n),
    .fetch_valid(fetch_valid),
    .fetch_instr(fetch_instr),
    .fetch_credit(fetch_credit),
    .dec_credit(dec_credit),
    .dec_valid(dec_valid),
    .dec_out(dec_out)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  // x0 about half the time
  function automatic logic [4:0] rand_reg();
    logic [31:0] r;
    r = rand_bits(6);
    return r[5] ? 5'd0 : r[4:0];
  endfunction

  function automatic logic [4:0] rand_nz_reg();
    logic [31:0] r;
    r = rand_bits(4);
    return {r[3:0], 1'b1};
  endfunction

  function automatic alu_op_type alu_for(input logic [2:0] f3, input logic alt);
    alu_op_type a;
    a = '0;
    case (f3)
      3'b000: if (alt) a.alu_sub = 1'b1; else a.alu_add = 1'b1;
      3'b001: a.alu_sll = 1'b1;
      3'b010: a.alu_slt = 1'b1;
      3'b011: a.alu_sltu = 1'b1;
      3'b100: a.alu_xor = 1'b1;
      3'b101: if (alt) a.alu_sra = 1'b1; else a.alu_srl = 1'b1;
      3'b110: a.alu_or = 1'b1;
      default: a.alu_and = 1'b1;
    endcase
    return a;
  endfunction

  function automatic decode_out_type ref_decode(input logic [31:0] w);
    decode_out_type d;
    logic [2:0] f3;
    logic [6:0] f7;
    logic rd_nz;
    int idx;
    f3 = w[14:12];
    f7 = w[31:25];
    rd_nz = w[11:7] != 5'd0;
    d = '0;
    d.legal = 1'b1;
    d.instr = w;
    d.rd = w[11:7];
    d.rs1 = w[19:15];
    d.rs2 = w[24:20];
    d.caddr = w[31:20];
    case (w[6:0])
      opcode_branch: begin
        d.branch = 1'b1;
        d.rden1 = 1'b1;
        d.rden2 = 1'b1;
        d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      end
      opcode_jal: begin
        d.jal = 1'b1;
        d.wren = rd_nz;
        d.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      opcode_jalr, opcode_load: begin
        d.jalr = w[6:0] == opcode_jalr;
        d.load = w[6:0] == opcode_load;
        d.wren = rd_nz;
        d.rden1 = 1'b1;
        d.imm = {{20{w[31]}}, w[31:20]};
      end
      opcode_store: begin
        d.store = 1'b1;
        d.rden1 = 1'b1;
        d.rden2 = 1'b1;
        d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      end
      opcode_auipc, opcode_lui: begin
        d.auipc = w[6:0] == opcode_auipc;
        d.lui = w[6:0] == opcode_lui;
        d.wren = rd_nz;
        d.imm = {w[31:12], 12'b0};
      end
      opcode_fence: d.fence = 1'b1;
      opcode_immediate: begin
        d.wren = rd_nz;
        d.rden1 = 1'b1;
        d.imm = {{20{w[31]}}, w[31:20]};
        d.alu_op = alu_for(f3, f3 == 3'b101 && w[30]);
        if (f3 == 3'b001) d.legal = f7 == 7'h00;
        if (f3 == 3'b101) d.legal = f7 == 7'h00 || f7 == 7'h20;
      end
      opcode_register: begin
        d.wren = rd_nz;
        d.rden1 = 1'b1;
        d.rden2 = 1'b1;
        if (f7 == 7'h01) begin
          // funct3 order matches the field order of the op structs
          d.mult = !f3[2];
          d.division = f3[2];
          if (f3[2]) d.div_op = 4'b1000 >> f3[1:0];
          else d.mul_op = 4'b1000 >> f3[1:0];
        end else begin
          d.alu_op = alu_for(f3, w[30]);
          d.legal = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        end
      end
      opcode_system: begin
        d.imm = {27'b0, w[19:15]};
        if (f3 == 3'b000) begin
          d.ecall = w[31:20] == csr_ecall;
          d.ebreak = w[31:20] == csr_ebreak;
          d.mret = w[31:20] == csr_mret;
          d.wfi = w[31:20] == csr_wfi;
          d.legal = d.ecall | d.ebreak | d.mret | d.wfi;
        end else if (f3 == 3'b100) begin
          d.legal = 1'b0;
        end else begin
          d.csrreg = 1'b1;
          d.wren = rd_nz;
          d.rden1 = !f3[2];
          // Write forms always write, set and clear forms always read
          d.cwren = (f3[1:0] == 2'b01) || (w[19:15] != 5'd0);
          d.crden = (f3[1:0] != 2'b01) || rd_nz;
          idx = (f3[2] ? 3 : 0) + int'(f3[1:0]) - 1;
          d.csr_op = 6'b100000 >> idx;
        end
      end
      default: d.legal = 1'b0;
    endcase
    if (w == `NOP_INSTR) begin
      d.alu_op.alu_add = 1'b0;
      d.nop = 1'b1;
    end
    return d;
  endfunction

  task automatic report_mismatch(input string name, input logic [191:0] exp,
                                 input logic [191:0] act);
    errors++;
    $display("error %s: expected %0h actual %0h", name, exp, act);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s", what);
  endtask

  task automatic print_summary();
    $display("decode_tb: %0d sent, %0d decoded, %0d errors", n_sent, n_out, errors);
  endtask

  task automatic abort_on_timeout(input string what);
    errors++;
    $display("timed out %s", what);
    print_summary();
    $display("sim failed");
    $finish;
  endtask

  task automatic send_word(input logic [31:0] w);
    logic [31:0] r;
    int waited;
    waited = 0;
    r = rand_bits(2);
    if (r[1:0] == 2'b00) begin
      fetch_valid = 1'b0;
      @(negedge clk);
    end
    while (send_credits == 0) begin
      fetch_valid = 1'b0;
      @(negedge clk);
      waited++;
      if (waited > wait_limit) abort_on_timeout("waiting for a fetch credit");
    end
    fetch_valid = 1'b1;
    fetch_instr = w;
    @(negedge clk);
    fetch_valid = 1'b0;
  endtask

  task automatic send_random_word(input logic [6:0] op);
    logic [31:0] r;
    r = rand_bits(25);
    send_word({r[24:0], op});
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (pending != 0 || held != 0) begin
      @(negedge clk);
      waited++;
      if (waited > wait_limit) abort_on_timeout("draining the decode pipeline");
    end
  endtask

  task automatic send_alu_words();
    logic [31:0] r;
    for (int f = 0; f < 8; f++) begin
      r = rand_bits(12);
      if (f == 1 || f == 5) r[11:5] = (f == 5 && r[0]) ? 7'h20 : 7'h00;
      send_word({r[11:0], rand_reg(), f[2:0], rand_reg(), opcode_immediate});
      send_word({7'h00, rand_reg(), rand_reg(), f[2:0], rand_reg(), opcode_register});
    end
    send_word({7'h20, rand_reg(), rand_reg(), 3'b000, rand_reg(), opcode_register});
    send_word({7'h20, rand_reg(), rand_reg(), 3'b101, rand_reg(), opcode_register});
    send_word({7'h20, 5'd4, 5'd5, 3'b001, 5'd6, opcode_register});
    send_word({7'h10, 5'd4, 5'd5, 3'b000, 5'd6, opcode_register});
    // Shift amounts with bit 25 set
    send_word({7'h01, 5'd3, 5'd1, 3'b001, 5'd2, opcode_immediate});
    send_word({7'h21, 5'd3, 5'd1, 3'b101, 5'd2, opcode_immediate});
    send_word(`NOP_INSTR);
  endtask

  task automatic send_system_words();
    logic [31:0] r;
    for (int f = 0; f < 8; f++) begin
      send_word({7'h01, rand_reg(), rand_reg(), f[2:0], rand_reg(), opcode_register});
    end
    send_word({csr_ecall, 13'b0, opcode_system});
    send_word({csr_ebreak, 13'b0, opcode_system});
    send_word({csr_mret, 13'b0, opcode_system});
    send_word({csr_wfi, 13'b0, opcode_system});
    send_word({12'h7c0, 13'b0, opcode_system});
    send_word({12'h300, 5'd1, 3'b100, 5'd1, opcode_system});
    for (int f = 1; f < 8; f++) begin
      for (int k = 0; k < 4; k++) begin
        r = rand_bits(12);
        if (f != 4) begin
          send_word({r[11:0], k[0] ? rand_nz_reg() : 5'd0, f[2:0],
                     k[1] ? rand_nz_reg() : 5'd0, opcode_system});
        end
      end
    end
  endtask

  task automatic send_control_words();
    logic [6:0] ops [12];
    ops = '{opcode_branch, opcode_jal, opcode_jalr, opcode_load, opcode_store,
            opcode_auipc, opcode_fence, opcode_lui, 7'h7f, 7'h00, 7'h5b, 7'h0b};
    for (int i = 0; i < 12; i++) begin
      send_random_word(ops[i]);
      if (i < 8) begin
        send_random_word(ops[i]);
        send_random_word(ops[i]);
      end
    end
  endtask

  // Sender credits and the model queue
  always @(posedge clk) begin
    if (!rst_n) begin
      sent_q.delete();
      pending <= 0;
      held <= 0;
      send_credits <= `QUEUE_DEPTH;
      n_sent <= 0;
      n_out <= 0;
      credit_pulses <= 0;
    end else begin
      if (fetch_valid) sent_q.push_back(fetch_instr);
      if (dec_valid && sent_q.size() != 0) void'(sent_q.pop_front());
      pending <= pending + int'(fetch_valid) - int'(dec_valid);
      held <= held + int'(dec_valid) - int'(dec_credit);
      send_credits <= send_credits - int'(fetch_valid) + int'(fetch_credit);
      n_sent <= n_sent + int'(fetch_valid);
      n_out <= n_out + int'(dec_valid);
      credit_pulses <= credit_pulses + int'(fetch_credit);
    end
  end

  always @(negedge clk) begin
    if (sent_q.size() != 0) exp_pkt = ref_decode(sent_q[0]);
    else exp_pkt = '0;
  end

  // Backend returns one credit per packet after a short random delay
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (rst_n && dec_valid) owed_q.push_back(cycle + 1 + int'(rand_bits(3)));
  end

  always @(negedge clk) begin
    dec_credit = 1'b0;
    if (rst_n && !hold_credits && owed_q.size() != 0 && owed_q[0] <= cycle) begin
      dec_credit = 1'b1;
      void'(owed_q.pop_front());
    end
  end

  a_in_order: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid |-> dec_out.instr == exp_pkt.instr)
    else report_mismatch("order", $sampled(exp_pkt.instr), $sampled(dec_out.instr));

  a_legal: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid |-> dec_out.legal == exp_pkt.legal)
    else report_mismatch("legal", $sampled(exp_pkt.legal), $sampled(dec_out.legal));

  a_imm: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid && exp_pkt.legal |-> dec_out.imm == exp_pkt.imm)
    else report_mismatch("imm", $sampled(exp_pkt.imm), $sampled(dec_out.imm));

  a_packet: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid && exp_pkt.legal |-> dec_out == exp_pkt)
    else report_mismatch("packet", $sampled(exp_pkt), $sampled(dec_out));

  a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid |-> pending != 0)
    else report_failure("dec_valid came with no word left to decode");

  a_backend_credit: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid |-> held < `BACKEND_CREDITS)
    else report_failure("dec_valid went out while the backend held no free credit");

  a_send_latency: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_valid && pending == 0 && held < `BACKEND_CREDITS |=> !dec_valid ##1 dec_valid)
    else report_failure("a word sent into the empty queue did not come out two cycles later");

  initial begin
    lfsr_state = 16'd72;
    rst_n = 1'b0;
    fetch_valid = 1'b0;
    fetch_instr = '0;
    dec_credit = 1'b0;
    hold_credits = 1'b0;
    cycle = 0;
    errors = 0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    assert (!dec_valid && !fetch_credit)
      else report_failure("dec_valid or fetch_credit high right after reset");
    send_word(`NOP_INSTR);
    wait_drained();
    send_alu_words();
    send_system_words();
    send_control_words();
    wait_drained();
    // Backend stalls until the queue is full and the sender has run dry
    hold_credits = 1'b1;
    repeat (`QUEUE_DEPTH + `BACKEND_CREDITS) send_random_word(opcode_immediate);
    repeat (24) @(negedge clk);
    hold_credits = 1'b0;
    wait_drained();
    send_random_word(opcode_lui);
    wait_drained();
    repeat (4) @(negedge clk);
    assert (n_out == n_sent) else report_mismatch("packet count", n_sent, n_out);
    assert (credit_pulses == n_out)
      else report_mismatch("fetch credit pulses", n_out, credit_pulses);
    assert (send_credits == `QUEUE_DEPTH)
      else report_mismatch("sender credits", `QUEUE_DEPTH, send_credits);
    print_summary();
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: decode_top.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/decode_pkg.sv
rtl/instr_queue.sv
rtl/predecoder.sv
rtl/postdecoder.sv
rtl/decode_stage.sv
rtl/decode_top.sv
testbench/decode_tb.sv
